//--- Makefile
# Verilator build and run of the MMU testbench

SIM = obj_dir/Vmmu_tb

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): list.f common/mmu_pkg.sv common/mmu_params.svh design/atom_req_fifo.sv \
        design/tlb_cache.sv pt_walk/pt_walk.sv design/mmu_top.sv \
        testbench/mmu_assert.sv testbench/mmu_tb.sv
	verilator --binary --timing --assert -Wno-fatal --top-module mmu_tb \
		-Mdir obj_dir -f list.f

run: compile
	./$(SIM)

clean:
	rm -rf obj_dir

//--- common/mmu_params.svh
`ifndef MMU_PARAMS_SVH
`define MMU_PARAMS_SVH

// Translation cache entries, a power of two
`define MMU_TLB_ENTRIES 4

// Slots in the memory read request buffer
`define MMU_FIFO_DEPTH 2

// One level-two memory atom and one page table entry
`define MMU_ATOM_BITS 256
`define MMU_ENTRY_BITS 32

// Page numbers and atom addresses
`define MMU_VPN_BITS 20
`define MMU_ATOM_ADDR_BITS 27

`endif

//--- common/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

   // Split view of a virtual page number as the two-level walk sees it
   typedef struct packed {
      logic [9:0] dir_idx;
      logic [9:0] tab_idx;
   } vpn_split_t;

   // The cache compares the whole page number as one tag, while the walker
   // needs the directory and table indices separately
   typedef union packed {
      logic [19:0] vpn;
      vpn_split_t  idx;
   } vaddr_u;

   // Low four bits of a directory or table entry
   typedef struct packed {
      logic [2:0] sw;
      logic       present;
   } pte_flags_t;

endpackage

`default_nettype wire

//--- design/atom_req_fifo.sv
`default_nettype none
`timescale 1ns/10ps
`include "mmu_params.svh"

module atom_req_fifo #(
   parameter int DEPTH  = `MMU_FIFO_DEPTH,
   parameter int ADDR_W = `MMU_ATOM_ADDR_BITS
) (
   input  wire                 tlb2ptw_clk,
   input  wire                 rst,
   input  wire                 req_valid,
   input  wire [ADDR_W-1:0]    req_addr,
   input  wire                 mem_stall,
   output logic                req_stall,
   output logic                mem_valid,
   output logic [ADDR_W-1:0]   mem_addr
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [ADDR_W-1:0]  slots [DEPTH];
   logic [PTR_W-1:0]   wr_ptr;
   logic [PTR_W-1:0]   rd_ptr;
   logic [CNT_W-1:0]   count;
   logic               push;
   logic               pop;

   // Advance a pointer around the ring, which need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
      if (p == PTR_W'(DEPTH - 1)) begin
         ptr_next = '0;
      end else begin
         ptr_next = p + 1'b1;
      end
   endfunction

   assign req_stall = (count == CNT_W'(DEPTH));
   assign mem_valid = (count != '0);
   assign mem_addr  = slots[rd_ptr];

   assign push = req_valid && !req_stall;
   assign pop  = mem_valid && !mem_stall;

   always_ff @(posedge tlb2ptw_clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= ptr_next(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= ptr_next(rd_ptr);
         end
         // Push and pop together leave the count unchanged
         count <= count + CNT_W'(push) - CNT_W'(pop);
      end
   end

   always_ff @(posedge tlb2ptw_clk) begin
      if (push) begin
         slots[wr_ptr] <= req_addr;
      end
   end

endmodule

`default_nettype wire

//--- design/mmu_top.sv
`default_nettype none
`timescale 1ns/10ps
`include "mmu_params.svh"

module mmu_top (
   input  wire                                tlb2ptw_clk,
   input  wire                                rst,

   // CPU lookup port
   input  wire                                lookup_valid,
   input  wire mmu_pkg::vaddr_u               lookup_vpn,
   input  wire [`MMU_VPN_BITS-1:0]            pagedir_base,
   input  wire                                tlb_flush,
   output wire                                lookup_ready,
   output wire                                result_valid,
   output wire [`MMU_VPN_BITS-1:0]            result_phys,
   output wire mmu_pkg::pte_flags_t           result_pd_flags,
   output wire mmu_pkg::pte_flags_t           result_pt_flags,

   // Level-two memory read port
   output wire                                mem_valid,
   output wire [`MMU_ATOM_ADDR_BITS-1:0]      mem_addr,
   input  wire                                mem_stall,
   input  wire [`MMU_ATOM_BITS-1:0]           mem_rdata,
   input  wire                                mem_rvalid
);

   wire                                walk_start;
   wire mmu_pkg::vaddr_u               walk_vpn;
   wire                                walk_done;
   wire [`MMU_VPN_BITS-1:0]            walk_phys;
   wire mmu_pkg::pte_flags_t           walk_pd_flags;
   wire mmu_pkg::pte_flags_t           walk_pt_flags;
   wire                                req_valid;
   wire [`MMU_ATOM_ADDR_BITS-1:0]      req_addr;
   wire                                req_stall;

   tlb_cache i_tlb_cache (
      .tlb2ptw_clk     (tlb2ptw_clk),
      .rst             (rst),
      .lookup_valid    (lookup_valid),
      .lookup_vpn      (lookup_vpn),
      .tlb_flush       (tlb_flush),
      .walk_done       (walk_done),
      .walk_phys       (walk_phys),
      .walk_pd_flags   (walk_pd_flags),
      .walk_pt_flags   (walk_pt_flags),
      .lookup_ready    (lookup_ready),
      .result_valid    (result_valid),
      .result_phys     (result_phys),
      .result_pd_flags (result_pd_flags),
      .result_pt_flags (result_pt_flags),
      .walk_start      (walk_start),
      .walk_vpn        (walk_vpn)
   );

   pt_walk i_pt_walk (
      .tlb2ptw_clk   (tlb2ptw_clk),
      .rst           (rst),
      .walk_start    (walk_start),
      .walk_vpn      (walk_vpn),
      .pagedir_base  (pagedir_base),
      .req_stall     (req_stall),
      .mem_rdata     (mem_rdata),
      .mem_rvalid    (mem_rvalid),
      .walk_done     (walk_done),
      .walk_phys     (walk_phys),
      .walk_pd_flags (walk_pd_flags),
      .walk_pt_flags (walk_pt_flags),
      .req_valid     (req_valid),
      .req_addr      (req_addr)
   );

   // Responses bypass the buffer and go straight back to the walker
   atom_req_fifo i_atom_req_fifo (
      .tlb2ptw_clk (tlb2ptw_clk),
      .rst         (rst),
      .req_valid   (req_valid),
      .req_addr    (req_addr),
      .mem_stall   (mem_stall),
      .req_stall   (req_stall),
      .mem_valid   (mem_valid),
      .mem_addr    (mem_addr)
   );

endmodule

`default_nettype wire

//--- design/tlb_cache.sv
`default_nettype none
`timescale 1ns/10ps
`include "mmu_params.svh"

module tlb_cache (
   input  wire                            tlb2ptw_clk,
   input  wire                            rst,
   input  wire                            lookup_valid,
   input  wire mmu_pkg::vaddr_u           lookup_vpn,
   input  wire                            tlb_flush,
   input  wire                            walk_done,
   input  wire [`MMU_VPN_BITS-1:0]        walk_phys,
   input  wire mmu_pkg::pte_flags_t       walk_pd_flags,
   input  wire mmu_pkg::pte_flags_t       walk_pt_flags,
   output logic                           lookup_ready,
   output logic                           result_valid,
   output logic [`MMU_VPN_BITS-1:0]       result_phys,
   output mmu_pkg::pte_flags_t            result_pd_flags,
   output mmu_pkg::pte_flags_t            result_pt_flags,
   output logic                           walk_start,
   output mmu_pkg::vaddr_u                walk_vpn
);

   localparam int N     = `MMU_TLB_ENTRIES;
   localparam int IDX_W = $clog2(N);

   logic [N-1:0]               ent_valid;
   logic [`MMU_VPN_BITS-1:0]   ent_tag [N];
   logic [`MMU_VPN_BITS-1:0]   ent_phys [N];
   mmu_pkg::pte_flags_t        ent_pd_flags [N];
   mmu_pkg::pte_flags_t        ent_pt_flags [N];
   logic [IDX_W-1:0]           rr_ptr;
   logic                       walking;
   logic                       hit;
   logic [IDX_W-1:0]           hit_idx;
   logic                       take;
   logic                       fill;

   // Busy while a walk is open and during the result pulse itself
   assign lookup_ready = !walking && !result_valid;
   assign take         = lookup_valid && lookup_ready;

   // Faulting walks are forwarded but never cached
   assign fill = walking && walk_done && walk_pd_flags.present && walk_pt_flags.present;

   always_comb begin
      hit     = 1'b0;
      hit_idx = '0;
      for (int i = 0; i < N; i++) begin
         if (ent_valid[i] && (ent_tag[i] == lookup_vpn.vpn)) begin
            hit     = 1'b1;
            hit_idx = IDX_W'(i);
         end
      end
   end

   always_ff @(posedge tlb2ptw_clk) begin
      if (rst) begin
         ent_valid    <= '0;
         rr_ptr       <= '0;
         walking      <= 1'b0;
         result_valid <= 1'b0;
         walk_start   <= 1'b0;
      end else begin
         result_valid <= 1'b0;
         walk_start   <= 1'b0;

         if (take && hit) begin
            result_valid <= 1'b1;
         end else if (take) begin
            walk_start <= 1'b1;
            walking    <= 1'b1;
         end

         if (walking && walk_done) begin
            walking      <= 1'b0;
            result_valid <= 1'b1;
         end

         // Round-robin victim, wraps since the entry count is a power of two
         if (fill) begin
            ent_valid[rr_ptr] <= 1'b1;
            rr_ptr            <= rr_ptr + 1'b1;
         end

         if (tlb_flush && lookup_ready) begin
            ent_valid <= '0;
         end
      end
   end

   always_ff @(posedge tlb2ptw_clk) begin
      if (take) begin
         walk_vpn <= lookup_vpn;
      end

      if (take && hit) begin
         result_phys     <= ent_phys[hit_idx];
         result_pd_flags <= ent_pd_flags[hit_idx];
         result_pt_flags <= ent_pt_flags[hit_idx];
      end else if (walking && walk_done) begin
         result_phys     <= walk_phys;
         result_pd_flags <= walk_pd_flags;
         result_pt_flags <= walk_pt_flags;
      end

      // walk_vpn still holds the page that missed
      if (fill) begin
         ent_tag[rr_ptr]      <= walk_vpn.vpn;
         ent_phys[rr_ptr]     <= walk_phys;
         ent_pd_flags[rr_ptr] <= walk_pd_flags;
         ent_pt_flags[rr_ptr] <= walk_pt_flags;
      end
   end

endmodule

`default_nettype wire

//--- list.f
+incdir+common
common/mmu_pkg.sv
design/atom_req_fifo.sv
design/tlb_cache.sv
pt_walk/pt_walk.sv
design/mmu_top.sv
testbench/mmu_assert.sv
testbench/mmu_tb.sv

//--- pt_walk/pt_walk.sv
`default_nettype none
`timescale 1ns/10ps
`include "mmu_params.svh"

module pt_walk (
   input  wire                                tlb2ptw_clk,
   input  wire                                rst,
   input  wire                                walk_start,
   input  wire mmu_pkg::vaddr_u               walk_vpn,
   input  wire [`MMU_VPN_BITS-1:0]            pagedir_base,
   input  wire                                req_stall,
   input  wire [`MMU_ATOM_BITS-1:0]           mem_rdata,
   input  wire                                mem_rvalid,
   output logic                               walk_done,
   output logic [`MMU_VPN_BITS-1:0]           walk_phys,
   output mmu_pkg::pte_flags_t                walk_pd_flags,
   output mmu_pkg::pte_flags_t                walk_pt_flags,
   output logic                               req_valid,
   output logic [`MMU_ATOM_ADDR_BITS-1:0]     req_addr
);

   localparam logic [1:0] ST_IDLE     = 2'd0;
   localparam logic [1:0] ST_READ_DIR = 2'd1;
   localparam logic [1:0] ST_READ_TAB = 2'd2;

   logic [1:0]                  state;
   mmu_pkg::vaddr_u             vpn_q;
   logic [`MMU_ENTRY_BITS-1:0]  pd_entry_q;
   logic [`MMU_ENTRY_BITS-1:0]  pt_entry_q;
   logic [`MMU_ENTRY_BITS-1:0]  rd_pd_entry;
   logic [`MMU_ENTRY_BITS-1:0]  rd_pt_entry;
   mmu_pkg::pte_flags_t         rd_pd_flags;
   logic                        start_take;
   logic                        dir_load;
   logic                        tab_load;

   // Each atom holds eight entries and the low three index bits pick one
   assign rd_pd_entry = mem_rdata[vpn_q.idx.dir_idx[2:0] * `MMU_ENTRY_BITS +: `MMU_ENTRY_BITS];
   assign rd_pt_entry = mem_rdata[vpn_q.idx.tab_idx[2:0] * `MMU_ENTRY_BITS +: `MMU_ENTRY_BITS];
   assign rd_pd_flags = rd_pd_entry[3:0];

   assign start_take = (state == ST_IDLE) && walk_start;
   assign dir_load   = (state == ST_READ_DIR) && mem_rvalid;
   assign tab_load   = (state == ST_READ_TAB) && mem_rvalid;

   // The walk result is read straight from the latched entries
   assign walk_pd_flags = pd_entry_q[3:0];
   assign walk_pt_flags = pt_entry_q[3:0];
   assign walk_phys     = pt_entry_q[`MMU_ENTRY_BITS-1 -: `MMU_VPN_BITS];

   always_ff @(posedge tlb2ptw_clk) begin
      if (rst) begin
         state     <= ST_IDLE;
         req_valid <= 1'b0;
         walk_done <= 1'b0;
      end else begin
         walk_done <= 1'b0;

         // A request drops once the buffer accepts it, so each level
         // issues exactly one read
         if (req_valid && !req_stall) begin
            req_valid <= 1'b0;
         end

         case (state)
            ST_IDLE: begin
               if (walk_start) begin
                  req_valid <= 1'b1;
                  state     <= ST_READ_DIR;
               end
            end
            ST_READ_DIR: begin
               if (mem_rvalid) begin
                  if (rd_pd_flags.present) begin
                     req_valid <= 1'b1;
                     state     <= ST_READ_TAB;
                  end else begin
                     // Missing page table, so the walk ends here as a fault
                     walk_done <= 1'b1;
                     state     <= ST_IDLE;
                  end
               end
            end
            ST_READ_TAB: begin
               if (mem_rvalid) begin
                  walk_done <= 1'b1;
                  state     <= ST_IDLE;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge tlb2ptw_clk) begin
      if (start_take) begin
         vpn_q    <= walk_vpn;
         req_addr <= {pagedir_base, walk_vpn.idx.dir_idx[9:3]};
      end

      if (dir_load) begin
         pd_entry_q <= rd_pd_entry;
         // Cleared so that a fault reports table flags of zero
         pt_entry_q <= '0;
         // The table base comes from the atom in flight, not yet from pd_entry_q
         req_addr   <= {rd_pd_entry[`MMU_ENTRY_BITS-1 -: `MMU_VPN_BITS],
                        vpn_q.idx.tab_idx[9:3]};
      end

      if (tab_load) begin
         pt_entry_q <= rd_pt_entry;
      end
   end

endmodule

`default_nettype wire

//--- testbench/mmu_assert.sv
`default_nettype none
`timescale 1ns/10ps
`include "mmu_params.svh"

module mmu_assert (
   input wire                             tlb2ptw_clk,
   input wire                             rst,
   input wire                             mem_valid,
   input wire                             mem_stall,
   input wire [`MMU_ATOM_ADDR_BITS-1:0]   mem_addr,
   input wire                             result_valid,
   input wire                             req_valid,
   input wire                             req_stall
);

   logic [3:0] occupancy;
   logic       push;
   logic       pop;

   assign push = req_valid && !req_stall;
   assign pop  = mem_valid && !mem_stall;

   // Shadow count of buffered requests, rebuilt from the handshakes alone
   always_ff @(posedge tlb2ptw_clk) begin
      if (rst) begin
         occupancy <= '0;
      end else begin
         occupancy <= occupancy + 4'(push) - 4'(pop);
      end
   end

   addr_held: assert property (@(posedge tlb2ptw_clk) disable iff (rst)
      (mem_valid && mem_stall) |=> (mem_valid && $stable(mem_addr)))
      else $error("mem_addr changed while the buffer head was stalled");

   result_pulse: assert property (@(posedge tlb2ptw_clk) disable iff (rst)
      result_valid |=> !result_valid)
      else $error("result_valid stayed high for two cycles");

   no_empty_pop: assert property (@(posedge tlb2ptw_clk) disable iff (rst)
      pop |-> (occupancy != '0))
      else $error("request buffer popped while empty");

endmodule

`default_nettype wire

//--- testbench/mmu_tb.sv
`default_nettype none
`timescale 1ns/10ps
`include "mmu_params.svh"

module mmu_tb;

   localparam logic [`MMU_VPN_BITS-1:0] PAGEDIR_BASE = 20'h00100;

   logic                               tlb2ptw_clk;
   logic                               rst;
   logic                               lookup_valid;
   mmu_pkg::vaddr_u                    lookup_vpn;
   logic [`MMU_VPN_BITS-1:0]           pagedir_base;
   logic                               tlb_flush;
   logic                               mem_stall = 1'b0;
   logic [`MMU_ATOM_BITS-1:0]          mem_rdata = '0;
   logic                               mem_rvalid = 1'b0;
   wire                                lookup_ready;
   wire                                result_valid;
   wire [`MMU_VPN_BITS-1:0]            result_phys;
   wire mmu_pkg::pte_flags_t           result_pd_flags;
   wire mmu_pkg::pte_flags_t           result_pt_flags;
   wire                                mem_valid;
   wire [`MMU_ATOM_ADDR_BITS-1:0]      mem_addr;

   // Sparse level-two memory and the reads still waiting for their response
   logic [`MMU_ATOM_BITS-1:0]          mem_image [logic [`MMU_ATOM_ADDR_BITS-1:0]];
   logic [`MMU_ATOM_ADDR_BITS-1:0]     pend_addr [$];
   int                                 pend_due [$];

   // Lookup and flush records in file order
   byte                                rec_kind [$];
   logic [`MMU_VPN_BITS-1:0]           rec_vpn [$];
   logic [`MMU_VPN_BITS-1:0]           rec_phys [$];
   logic [3:0]                         rec_pd [$];
   logic [3:0]                         rec_pt [$];
   int                                 rec_reqs [$];
   string                              rec_name [$];
   int                                 rec_line [$];

   integer                             seed = 32'h34e;
   int                                 cycles = 0;
   int                                 cycle_limit = 0;
   int                                 vector_lines = 0;
   int                                 pop_count = 0;

   mmu_top i_mmu_top (
      .tlb2ptw_clk     (tlb2ptw_clk),
      .rst             (rst),
      .lookup_valid    (lookup_valid),
      .lookup_vpn      (lookup_vpn),
      .pagedir_base    (pagedir_base),
      .tlb_flush       (tlb_flush),
      .lookup_ready    (lookup_ready),
      .result_valid    (result_valid),
      .result_phys     (result_phys),
      .result_pd_flags (result_pd_flags),
      .result_pt_flags (result_pt_flags),
      .mem_valid       (mem_valid),
      .mem_addr        (mem_addr),
      .mem_stall       (mem_stall),
      .mem_rdata       (mem_rdata),
      .mem_rvalid      (mem_rvalid)
   );

   bind mmu_top mmu_assert i_mmu_assert (
      .tlb2ptw_clk  (tlb2ptw_clk),
      .rst          (rst),
      .mem_valid    (mem_valid),
      .mem_stall    (mem_stall),
      .mem_addr     (mem_addr),
      .result_valid (result_valid),
      .req_valid    (req_valid),
      .req_stall    (req_stall)
   );

   initial begin
      tlb2ptw_clk = 1'b0;
      forever #20 tlb2ptw_clk = ~tlb2ptw_clk;
   end

   task automatic abort_run(input string reason);
      $display("FAIL: see errors above");
      $fatal(1, "%s", reason);
   endtask

   task automatic report_mismatch(input string test_name, input string field,
                                  input logic [31:0] expected, input logic [31:0] actual);
      $display("error: %s %s expected %h actual %h", test_name, field, expected, actual);
      $display("FAIL: see errors above");
      $fatal(1, "wrong value in %s", test_name);
   endtask

   // Addresses never loaded read as zero, which is a non-present entry
   function automatic logic [`MMU_ATOM_BITS-1:0] read_atom(
      input logic [`MMU_ATOM_ADDR_BITS-1:0] addr);
      if (mem_image.exists(addr)) begin
         return mem_image[addr];
      end
      return '0;
   endfunction

   // The data field may be written as several groups of hex digits
   function automatic logic [`MMU_ATOM_BITS-1:0] atom_from_line(input string line,
                                                                output int digits);
      logic [`MMU_ATOM_BITS-1:0] data;
      int                        field;
      bit                        in_field;
      byte                       c;
      data     = '0;
      digits   = 0;
      field    = 0;
      in_field = 1'b0;
      for (int i = 0; i < line.len(); i++) begin
         c = line.getc(i);
         if (c == " " || c == 8'd9 || c == 8'd10 || c == 8'd13) begin
            in_field = 1'b0;
         end else begin
            if (!in_field) begin
               field++;
               in_field = 1'b1;
            end
            // Fields one and two are the record letter and the atom address
            if (field >= 3) begin
               if (c >= "a") begin
                  c = c - "a" + 8'd10;
               end else if (c >= "A") begin
                  c = c - "A" + 8'd10;
               end else begin
                  c = c - "0";
               end
               data = {data[`MMU_ATOM_BITS-5:0], c[3:0]};
               digits++;
            end
         end
      end
      return data;
   endfunction

   always @(posedge tlb2ptw_clk) begin
      cycles <= cycles + 1;
      if (cycle_limit != 0 && cycles >= cycle_limit) begin
         abort_run($sformatf("run timed out after %0d cycles", cycles));
      end
   end

   // Memory model with random back-pressure and in-order delayed responses
   always @(posedge tlb2ptw_clk) begin
      int r;
      int due;
      r = $random(seed);
      mem_stall  <= (r[1:0] == 2'b00);
      mem_rvalid <= 1'b0;
      if (pend_addr.size() != 0 && pend_due[0] <= cycles) begin
         mem_rvalid <= 1'b1;
         mem_rdata  <= read_atom(pend_addr.pop_front());
         void'(pend_due.pop_front());
      end
      if (mem_valid && !mem_stall) begin
         r   = $random(seed);
         due = cycles + 1 + int'(r[1:0]);
         if (pend_due.size() != 0 && due <= pend_due[$]) begin
            due = pend_due[$] + 1;
         end
         pend_addr.push_back(mem_addr);
         pend_due.push_back(due);
         pop_count <= pop_count + 1;
      end
   end

   task automatic load_vectors();
      int                             fd;
      int                             n;
      int                             line_no;
      int                             reqs;
      int                             digits;
      byte                            kind;
      string                          line;
      string                          name;
      logic [`MMU_ATOM_ADDR_BITS-1:0] addr;
      logic [`MMU_ATOM_BITS-1:0]      atom;
      logic [`MMU_VPN_BITS-1:0]       vpn;
      logic [`MMU_VPN_BITS-1:0]       phys;
      logic [3:0]                     pd;
      logic [3:0]                     pt;
      fd = $fopen("testbench/mmu_vectors.txt", "r");
      assert (fd != 0) else abort_run("cannot open testbench/mmu_vectors.txt");
      line_no = 0;
      while ($fgets(line, fd) != 0) begin
         line_no++;
         kind = line.getc(0);
         if (kind == "M") begin
            n    = $sscanf(line, "M %h", addr);
            atom = atom_from_line(line, digits);
            assert (n == 1 && digits > 0 && digits <= `MMU_ATOM_BITS / 4)
               else abort_run($sformatf("bad memory line %0d", line_no));
            mem_image[addr] = atom;
            vector_lines++;
         end else if (kind == "L" || kind == "F") begin
            vpn  = '0;
            phys = '0;
            pd   = '0;
            pt   = '0;
            reqs = 0;
            name = "flush";
            if (kind == "L") begin
               n = $sscanf(line, "L %h %h %h %h %d %s", vpn, phys, pd, pt, reqs, name);
               assert (n == 6) else abort_run($sformatf("bad lookup line %0d", line_no));
            end
            rec_kind.push_back(kind);
            rec_vpn.push_back(vpn);
            rec_phys.push_back(phys);
            rec_pd.push_back(pd);
            rec_pt.push_back(pt);
            rec_reqs.push_back(reqs);
            rec_name.push_back(name);
            rec_line.push_back(line_no);
            vector_lines++;
         end else if (kind != "#" && kind != 8'd10 && kind != 8'd13) begin
            abort_run($sformatf("unknown record on vector line %0d", line_no));
         end
      end
      $fclose(fd);
   endtask

   task automatic flush_cache();
      @(posedge tlb2ptw_clk);
      tlb_flush <= 1'b1;
      @(posedge tlb2ptw_clk);
      while (!lookup_ready) begin
         @(posedge tlb2ptw_clk);
      end
      tlb_flush <= 1'b0;
   endtask

   task automatic check_lookup(input int idx);
      int    pops_before;
      int    waited;
      string tname;
      tname = $sformatf("lookup line %0d (%s)", rec_line[idx], rec_name[idx]);
      @(posedge tlb2ptw_clk);
      lookup_valid   <= 1'b1;
      lookup_vpn.vpn <= rec_vpn[idx];
      @(posedge tlb2ptw_clk);
      while (!lookup_ready) begin
         @(posedge tlb2ptw_clk);
      end
      // The DUT took the lookup on this edge
      lookup_valid <= 1'b0;
      pops_before = pop_count;
      waited = 0;
      do begin
         @(posedge tlb2ptw_clk);
         waited++;
      end while (!result_valid);

      assert (result_phys == rec_phys[idx])
         else report_mismatch(tname, "phys", 32'(rec_phys[idx]), 32'(result_phys));
      assert (result_pd_flags == rec_pd[idx])
         else report_mismatch(tname, "pd flags", 32'(rec_pd[idx]), 32'(result_pd_flags));
      assert (result_pt_flags == rec_pt[idx])
         else report_mismatch(tname, "pt flags", 32'(rec_pt[idx]), 32'(result_pt_flags));
      assert (pop_count - pops_before == rec_reqs[idx])
         else report_mismatch(tname, "requests", rec_reqs[idx], pop_count - pops_before);
      if (rec_reqs[idx] == 0) begin
         assert (waited == 1) else report_mismatch(tname, "hit latency", 1, waited);
      end
   endtask

   initial begin
      rst          = 1'b1;
      lookup_valid = 1'b0;
      lookup_vpn   = '0;
      pagedir_base = PAGEDIR_BASE;
      tlb_flush    = 1'b0;
      load_vectors();
      cycle_limit = 200 * vector_lines;
      repeat (3) @(posedge tlb2ptw_clk);
      rst <= 1'b0;
      for (int i = 0; i < rec_kind.size(); i++) begin
         if (rec_kind[i] == "F") begin
            flush_cache();
         end else begin
            check_lookup(i);
         end
      end
      repeat (4) @(posedge tlb2ptw_clk);
      $display("PASS: all tests");
      $finish;
   end

endmodule

`default_nettype wire

//--- testbench/mmu_vectors.txt
# M atom_addr atom_data (entry 7 on the left down to entry 0 on the right)
# L vpn phys pd_flags pt_flags requests name, and F flushes the cache
# The directory base is 00100, so the directory atom sits at 0008000
M 0008000 0000000000000000000000000000000000000000004000050030000200200003
M 0010000 00000000000000000000000055555007 0F00D00F0077700912345003ABCDE001
M 0020001 0000000000000000000000000000000000000000000000009ABCD00B00000000
L 00000 ABCDE 3 1 2 first_walk
L 00400 00000 2 0 1 fault
L 00400 00000 2 0 1 fault_again
L 00000 ABCDE 3 1 0 hit_first
F
L 00000 ABCDE 3 1 2 after_flush
L 00001 12345 3 3 2 fill_p1
L 00002 00777 3 9 2 fill_p2
L 00003 0F00D 3 F 2 fill_p3
L 00004 55555 3 7 2 fill_p4
L 00000 ABCDE 3 1 2 evicted_first
L 00004 55555 3 7 0 hit_p4
L 00809 9ABCD 5 B 2 second_table
L 00003 0F00D 3 F 0 hit_p3
